//--- Bender.yml
package:
  name: fft16_front

sources:
  - files:
      - common/fft_types_pkg.sv
      - common/fft_twiddle_pkg.sv
      - sdf_stage/sdf_stage_ctrl.sv
      - sdf_stage/sdf_butterfly.sv
      - src/twiddle_rotator.sv
      - src/fixed_saturator.sv
      - src/fft16_front.sv

  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/fft16_front_tb.sv

//--- common/fft_twiddle_pkg.sv
package fft_twiddle_pkg;

        // Twiddle word and its fixed point scale (1.0 == 512)
        localparam int TW_W    = 11;
        localparam int TW_FRAC = 9;

        //////////////////////////////////////////////////
        // W16^n for n = 0..7
        //////////////////////////////////////////////////

        // Real part, round(512 * cos(2*pi*n/16))
        localparam logic signed [TW_W-1:0] tw_re_table [8] = '{
                11'sd512,
                11'sd473,
                11'sd362,
                11'sd196,
                11'sd0,
                -11'sd196,
                -11'sd362,
                -11'sd473
        };

        // Imaginary part, round(-512 * sin(2*pi*n/16))
        localparam logic signed [TW_W-1:0] tw_im_table [8] = '{
                11'sd0,
                -11'sd196,
                -11'sd362,
                -11'sd473,
                -11'sd512,
                -11'sd473,
                -11'sd362,
                -11'sd196
        };

endpackage

//--- common/fft_types_pkg.sv
package fft_types_pkg;

        // Frame length of the transform
        localparam int FFT_POINTS = 16;

        //////////////////////////////////////////////////
        // Stage phase
        //////////////////////////////////////////////////

        // First half of a block is loaded into the delay line,
        // second half is combined with it
        typedef enum logic {
                PHASE_FILL,
                PHASE_EMIT
        } stage_phase_t;

        //////////////////////////////////////////////////
        // Butterfly output tag
        //////////////////////////////////////////////////

        // Sums need no rotation, differences get a twiddle
        typedef enum logic {
                KIND_SUM,
                KIND_DIFF
        } sample_kind_t;

endpackage

//--- sdf_stage/sdf_butterfly.sv
module sdf_butterfly
        import fft_types_pkg::*;
#(
        parameter int DELAY  = 8,
        parameter int DATA_W = 10
) (
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       in_valid,
        input  logic signed [DATA_W-1:0]   in_re,
        input  logic signed [DATA_W-1:0]   in_im,
        output logic                       out_valid,
        output sample_kind_t               out_kind,
        output logic [$clog2(DELAY)-1:0]   out_index,
        output logic signed [DATA_W:0]     out_re,
        output logic signed [DATA_W:0]     out_im
);

        localparam int IDX_W = $clog2(DELAY);

        stage_phase_t           phase;
        logic [IDX_W-1:0]       index;

        // Set once a block has reached its emit half
        logic                   seen_block;

        logic signed [DATA_W:0] line_re [DELAY];
        logic signed [DATA_W:0] line_im [DELAY];

        logic signed [DATA_W:0] head_re;
        logic signed [DATA_W:0] head_im;
        logic signed [DATA_W:0] ext_re;
        logic signed [DATA_W:0] ext_im;
        logic signed [DATA_W:0] feed_re;
        logic signed [DATA_W:0] feed_im;
        logic signed [DATA_W:0] res_re;
        logic signed [DATA_W:0] res_im;

        sdf_stage_ctrl #(
                .DELAY    (DELAY)
        ) i_ctrl (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_valid (in_valid),
                .phase    (phase),
                .index    (index)
        );

        //////////////////////////////////////////////////
        // Butterfly datapath
        //////////////////////////////////////////////////

        assign head_re = line_re[DELAY-1];
        assign head_im = line_im[DELAY-1];

        // Grow by one bit so sum and difference cannot wrap
        assign ext_re = {in_re[DATA_W-1], in_re};
        assign ext_im = {in_im[DATA_W-1], in_im};

        always_comb begin
                if (phase == PHASE_EMIT) begin
                        // Difference goes back into the line
                        feed_re = head_re - ext_re;
                        feed_im = head_im - ext_im;
                        res_re  = head_re + ext_re;
                        res_im  = head_im + ext_im;
                end else begin
                        // Head holds a difference of the last block
                        feed_re = ext_re;
                        feed_im = ext_im;
                        res_re  = head_re;
                        res_im  = head_im;
                end
        end

        // Delay line, moves only with accepted samples
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        line_re[0] <= feed_re;
                        line_im[0] <= feed_im;
                        for (int i = 1; i < DELAY; i++) begin
                                line_re[i] <= line_re[i-1];
                                line_im[i] <= line_im[i-1];
                        end
                end
        end

        //////////////////////////////////////////////////
        // Output stage
        //////////////////////////////////////////////////

        // No differences exist until the first emit half has run
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid  <= 1'b0;
                        seen_block <= 1'b0;
                end else begin
                        out_valid <= in_valid && (phase == PHASE_EMIT || seen_block);
                        if (in_valid && phase == PHASE_EMIT) begin
                                seen_block <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid) begin
                        out_re    <= res_re;
                        out_im    <= res_im;
                        out_index <= index;
                        out_kind  <= (phase == PHASE_EMIT) ? KIND_SUM : KIND_DIFF;
                end
        end

endmodule

//--- sdf_stage/sdf_stage_ctrl.sv
module sdf_stage_ctrl
        import fft_types_pkg::*;
#(
        parameter int DELAY = 8
) (
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       in_valid,
        output stage_phase_t               phase,
        output logic [$clog2(DELAY)-1:0]   index
);

        localparam int IDX_W = $clog2(DELAY);
        localparam int CNT_W = IDX_W + 1;

        // Accepted samples within the current block of 2*DELAY
        logic [CNT_W-1:0] cnt;

        //////////////////////////////////////////////////
        // Sample counter
        //////////////////////////////////////////////////

        // DELAY is a power of two, so the counter wraps on its own
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        cnt <= '0;
                end else if (in_valid) begin
                        cnt <= cnt + 1'b1;
                end
        end

        //////////////////////////////////////////////////
        // Phase and position
        //////////////////////////////////////////////////

        // Top bit picks the half, the rest is the slot within it
        always_comb begin
                if (cnt[CNT_W-1]) begin
                        phase = PHASE_EMIT;
                end else begin
                        phase = PHASE_FILL;
                end
                index = cnt[IDX_W-1:0];
        end

endmodule

//--- sim.f
common/fft_types_pkg.sv
common/fft_twiddle_pkg.sv
sdf_stage/sdf_stage_ctrl.sv
sdf_stage/sdf_butterfly.sv
src/twiddle_rotator.sv
src/fixed_saturator.sv
src/fft16_front.sv
test/tb_clock_gen.sv
test/fft16_front_tb.sv

//--- src/fft16_front.sv
module fft16_front
        import fft_types_pkg::*;
#(
        parameter int IN_W      = 10,
        parameter int OUT_W     = 12,
        parameter int SAT_SHIFT = 1
) (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      in_valid,
        input  logic signed [IN_W-1:0]    in_re,
        input  logic signed [IN_W-1:0]    in_im,
        output logic                      out_valid,
        output logic signed [OUT_W-1:0]   out_re,
        output logic signed [OUT_W-1:0]   out_im
);

        // Stage delays of the radix-2 SDF chain
        localparam int DELAY_A = FFT_POINTS / 2;
        localparam int DELAY_B = FFT_POINTS / 4;
        localparam int IDX_W   = $clog2(DELAY_A);

        // Word growth along the chain
        localparam int A_W = IN_W + 1;
        localparam int R_W = IN_W + 4;
        localparam int B_W = IN_W + 5;

        logic                   a_valid;
        sample_kind_t           a_kind;
        logic [IDX_W-1:0]       a_index;
        logic signed [A_W-1:0]  a_re;
        logic signed [A_W-1:0]  a_im;

        logic                   r_valid;
        logic signed [R_W-1:0]  r_re;
        logic signed [R_W-1:0]  r_im;

        logic                   b_valid;
        logic signed [B_W-1:0]  b_re;
        logic signed [B_W-1:0]  b_im;

        //////////////////////////////////////////////////
        // Stage A, delay 8
        //////////////////////////////////////////////////

        sdf_butterfly #(
                .DELAY     (DELAY_A),
                .DATA_W    (IN_W)
        ) i_stage_a (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_re     (in_re),
                .in_im     (in_im),
                .out_valid (a_valid),
                .out_kind  (a_kind),
                .out_index (a_index),
                .out_re    (a_re),
                .out_im    (a_im)
        );

        // W16^n on the differences
        twiddle_rotator #(
                .DATA_W    (A_W)
        ) i_rot (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (a_valid),
                .in_kind   (a_kind),
                .in_index  (a_index),
                .in_re     (a_re),
                .in_im     (a_im),
                .out_valid (r_valid),
                .out_re    (r_re),
                .out_im    (r_im)
        );

        //////////////////////////////////////////////////
        // Stage B, delay 4, and output narrowing
        //////////////////////////////////////////////////

        // Tag and index of stage B feed nothing yet
        sdf_butterfly #(
                .DELAY     (DELAY_B),
                .DATA_W    (R_W)
        ) i_stage_b (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (r_valid),
                .in_re     (r_re),
                .in_im     (r_im),
                .out_valid (b_valid),
                .out_kind  (),
                .out_index (),
                .out_re    (b_re),
                .out_im    (b_im)
        );

        fixed_saturator #(
                .IN_W      (B_W),
                .OUT_W     (OUT_W),
                .SHIFT     (SAT_SHIFT)
        ) i_sat (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (b_valid),
                .in_re     (b_re),
                .in_im     (b_im),
                .out_valid (out_valid),
                .out_re    (out_re),
                .out_im    (out_im)
        );

endmodule

//--- src/fixed_saturator.sv
module fixed_saturator #(
        parameter int IN_W  = 15,
        parameter int OUT_W = 12,
        parameter int SHIFT = 1
) (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      in_valid,
        input  logic signed [IN_W-1:0]    in_re,
        input  logic signed [IN_W-1:0]    in_im,
        output logic                      out_valid,
        output logic signed [OUT_W-1:0]   out_re,
        output logic signed [OUT_W-1:0]   out_im
);

        // Signed range of the output word, held at input width
        localparam logic signed [IN_W-1:0] SAT_MAX = IN_W'((1 << (OUT_W - 1)) - 1);
        localparam logic signed [IN_W-1:0] SAT_MIN = -SAT_MAX - 1;

        // Shift down, then clamp
        function automatic logic signed [OUT_W-1:0] shift_clamp(
                input logic signed [IN_W-1:0] v
        );
                logic signed [IN_W-1:0] s;
                s = v >>> SHIFT;
                if (s > SAT_MAX) begin
                        return SAT_MAX[OUT_W-1:0];
                end else if (s < SAT_MIN) begin
                        return SAT_MIN[OUT_W-1:0];
                end
                return s[OUT_W-1:0];
        endfunction

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= in_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid) begin
                        out_re <= shift_clamp(in_re);
                        out_im <= shift_clamp(in_im);
                end
        end

endmodule

//--- src/twiddle_rotator.sv
module twiddle_rotator
        import fft_types_pkg::*;
        import fft_twiddle_pkg::*;
#(
        parameter int DATA_W = 11
) (
        input  logic                                   clk,
        input  logic                                   rst_n,
        input  logic                                   in_valid,
        input  sample_kind_t                           in_kind,
        input  logic [$clog2(FFT_POINTS/2)-1:0]        in_index,
        input  logic signed [DATA_W-1:0]               in_re,
        input  logic signed [DATA_W-1:0]               in_im,
        output logic                                   out_valid,
        output logic signed [DATA_W+2:0]               out_re,
        output logic signed [DATA_W+2:0]               out_im
);

        localparam int RES_W  = DATA_W + 3;
        // Full complex product, one bit for the add
        localparam int PROD_W = DATA_W + TW_W + 1;

        logic signed [TW_W-1:0]   tw_re;
        logic signed [TW_W-1:0]   tw_im;
        logic signed [PROD_W-1:0] prod_re;
        logic signed [PROD_W-1:0] prod_im;

        //////////////////////////////////////////////////
        // Coefficient lookup and multiply
        //////////////////////////////////////////////////

        assign tw_re = tw_re_table[in_index];
        assign tw_im = tw_im_table[in_index];

        always_comb begin
                if (in_kind == KIND_DIFF) begin
                        // (a + jb)(c + jd)
                        prod_re = in_re * tw_re - in_im * tw_im;
                        prod_im = in_re * tw_im + in_im * tw_re;
                end else begin
                        // Times one, just align to the twiddle scale
                        prod_re = PROD_W'(in_re) <<< TW_FRAC;
                        prod_im = PROD_W'(in_im) <<< TW_FRAC;
                end
        end

        //////////////////////////////////////////////////
        // Output register
        //////////////////////////////////////////////////

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= in_valid;
                end
        end

        // Dropping the low TW_FRAC bits rounds toward minus infinity
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        out_re <= prod_re[TW_FRAC +: RES_W];
                        out_im <= prod_im[TW_FRAC +: RES_W];
                end
        end

endmodule

//--- test/fft16_front_tb.sv
module fft16_front_tb
        import fft_types_pkg::*;
();

        localparam int CLK_PERIOD = 40;
        localparam int IN_W       = 10;
        localparam int OUT_W      = 12;
        localparam int SAT_SHIFT  = 1;
        localparam int TW_SHIFT   = 9;
        localparam int N_RANDOM   = 50;
        localparam int N_CORNER   = 4;
        localparam int N_PARTIAL  = 7;

        // Each data frame is followed by two zero frames
        localparam int TOTAL_SAMPLES =
                FFT_POINTS * 3 * (2 + 2 * N_RANDOM + N_CORNER + 1) + N_PARTIAL;
        localparam int WATCHDOG_TIME = (TOTAL_SAMPLES + 64) * 4 * CLK_PERIOD;
        localparam real PI = 3.14159265358979;

        // Fresh frame and first zero frame come out in full
        // Last zero frame only gets the sums of its first stage-B block out
        localparam int RESULTS_AFTER_RESET = 2 * FFT_POINTS + FFT_POINTS / 4;

        logic                    clk;
        logic                    rst_n;
        logic                    in_valid;
        logic signed [IN_W-1:0]  in_re;
        logic signed [IN_W-1:0]  in_im;
        logic                    out_valid;
        logic signed [OUT_W-1:0] out_re;
        logic signed [OUT_W-1:0] out_im;

        int unsigned lcg_state = 18905;

        // W16^n scaled by 512, built from $cos and $sin
        int tw_c [8];
        int tw_s [8];

        int frame_re [FFT_POINTS];
        int frame_im [FFT_POINTS];
        int ref_re [FFT_POINTS];
        int ref_im [FFT_POINTS];
        int saved_re [N_RANDOM * FFT_POINTS];
        int saved_im [N_RANDOM * FFT_POINTS];

        // Expected output stream, in the order the DUT produces it
        logic signed [OUT_W-1:0] exp_re_q [$];
        logic signed [OUT_W-1:0] exp_im_q [$];
        bit                      exp_chk_q [$];
        int                      exp_tag_q [$];

        bit discard;
        int frame_count;
        int pending_checks;
        int needed_count;
        int checked_count;
        int seen_count;

        tb_clock_gen #(
                .PERIOD    (CLK_PERIOD)
        ) i_clk (
                .clk       (clk)
        );

        fft16_front i_dut (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_re     (in_re),
                .in_im     (in_im),
                .out_valid (out_valid),
                .out_re    (out_re),
                .out_im    (out_im)
        );

        //////////////////////////////////////////////////
        // Helpers
        //////////////////////////////////////////////////

        function automatic int unsigned lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        function automatic int random_sample();
                int unsigned r;
                r = lcg_next();
                return int'($signed(r[29:20]));
        endfunction

        function automatic int round_twiddle(input real x);
                if (x >= 0.0) begin
                        return $rtoi(x + 0.5);
                end
                return -$rtoi(0.5 - x);
        endfunction

        function automatic void init_twiddles();
                for (int n = 0; n < 8; n++) begin
                        tw_c[n] = round_twiddle(512.0 * $cos(2.0 * PI * real'(n) / 16.0));
                        tw_s[n] = round_twiddle(-512.0 * $sin(2.0 * PI * real'(n) / 16.0));
                end
        endfunction

        function automatic int shift_clamp(input int v);
                int s;
                s = v >>> SAT_SHIFT;
                if (s > 2047) begin
                        return 2047;
                end else if (s < -2048) begin
                        return -2048;
                end
                return s;
        endfunction

        // Expected 16 outputs of frame_re/frame_im into ref_re/ref_im
        function automatic void fft16_reference();
                int yr [FFT_POINTS];
                int yi [FFT_POINTS];
                int dr;
                int di;
                int k;
                for (int n = 0; n < 8; n++) begin
                        yr[n] = frame_re[n] + frame_re[n+8];
                        yi[n] = frame_im[n] + frame_im[n+8];
                        dr    = frame_re[n] - frame_re[n+8];
                        di    = frame_im[n] - frame_im[n+8];
                        // Floor after the complex product
                        yr[n+8] = (dr * tw_c[n] - di * tw_s[n]) >>> TW_SHIFT;
                        yi[n+8] = (dr * tw_s[n] + di * tw_c[n]) >>> TW_SHIFT;
                end
                for (int h = 0; h < 2; h++) begin
                        for (int j = 0; j < 4; j++) begin
                                k = 8 * h + j;
                                ref_re[k]     = shift_clamp(yr[k] + yr[k+4]);
                                ref_im[k]     = shift_clamp(yi[k] + yi[k+4]);
                                ref_re[k + 4] = shift_clamp(yr[k] - yr[k+4]);
                                ref_im[k + 4] = shift_clamp(yi[k] - yi[k+4]);
                        end
                end
        endfunction

        task automatic report_failure(input string what);
                $display("%s", what);
                $display("** FAIL **");
                $fatal(1);
        endtask

        task automatic compare_sample(
                input string                   name,
                input logic signed [OUT_W-1:0] expected,
                input logic signed [OUT_W-1:0] actual,
                input sample_kind_t            kind,
                input int                      tag
        );
                string kind_name;
                kind_name = (kind == KIND_SUM) ? "sum" : "diff";
                if (actual !== expected) begin
                        report_failure($sformatf(
                                "mismatch at %0t: %s expected %0d, got %0d (frame %0d, slot %0d, %s)",
                                $time, name, expected, actual, tag / FFT_POINTS,
                                tag % FFT_POINTS, kind_name));
                end
        endtask

        task automatic clear_frame();
                for (int k = 0; k < FFT_POINTS; k++) begin
                        frame_re[k] = 0;
                        frame_im[k] = 0;
                        ref_re[k]   = 0;
                        ref_im[k]   = 0;
                end
        endtask

        task automatic queue_expected(input bit check);
                for (int k = 0; k < FFT_POINTS; k++) begin
                        exp_re_q.push_back(OUT_W'(ref_re[k]));
                        exp_im_q.push_back(OUT_W'(ref_im[k]));
                        exp_chk_q.push_back(check);
                        exp_tag_q.push_back(frame_count * FFT_POINTS + k);
                end
                if (check) begin
                        pending_checks += FFT_POINTS;
                        needed_count   += FFT_POINTS;
                end
                frame_count++;
        endtask

        task automatic go_idle();
                in_valid = 1'b0;
                in_re    = '0;
                in_im    = '0;
        endtask

        // One sample per falling edge, optionally followed by idle cycles
        task automatic drive_sample(input int re, input int im, input bit with_gaps);
                int gap;
                in_valid = 1'b1;
                in_re    = IN_W'(re);
                in_im    = IN_W'(im);
                @(negedge clk);
                if (with_gaps && (lcg_next() % 4 == 0)) begin
                        gap = 1 + int'(lcg_next() % 2);
                        go_idle();
                        repeat (gap) @(negedge clk);
                end
        endtask

        task automatic drive_frame(input bit with_gaps);
                for (int k = 0; k < FFT_POINTS; k++) begin
                        drive_sample(frame_re[k], frame_im[k], with_gaps);
                end
                go_idle();
        endtask

        task automatic send_flush(input bit with_gaps);
                repeat (2) begin
                        clear_frame();
                        fft16_reference();
                        queue_expected(1'b0);
                        drive_frame(with_gaps);
                end
        endtask

        task automatic send_checked_frame(input bit with_gaps);
                fft16_reference();
                queue_expected(1'b1);
                drive_frame(with_gaps);
                send_flush(with_gaps);
        endtask

        task automatic load_corner(input int c);
                for (int k = 0; k < FFT_POINTS; k++) begin
                        case (c)
                                0: begin
                                        frame_re[k] = 511;
                                        frame_im[k] = -512;
                                end
                                1: begin
                                        frame_re[k] = (k < 8) ? 511 : -512;
                                        frame_im[k] = (k < 8) ? 511 : -512;
                                end
                                2: begin
                                        frame_re[k] = (k < 8) ? 511 : -512;
                                        frame_im[k] = (k < 8) ? -512 : 511;
                                end
                                default: begin
                                        frame_re[k] = -512;
                                        frame_im[k] = -512;
                                end
                        endcase
                end
        endtask

        task automatic wait_checks_done();
                while (pending_checks != 0) begin
                        @(negedge clk);
                end
        endtask

        //////////////////////////////////////////////////
        // Output comparison
        //////////////////////////////////////////////////

        always @(posedge clk) begin : compare_outputs
                logic signed [OUT_W-1:0] want_re;
                logic signed [OUT_W-1:0] want_im;
                bit                      chk;
                int                      tag;
                sample_kind_t            kind;
                if (rst_n === 1'b1 && out_valid === 1'b1) begin
                        seen_count++;
                        if (!discard) begin
                                if (exp_re_q.size() == 0) begin
                                        report_failure(
                                                "out_valid asserted while no result was expected");
                                end
                                want_re = exp_re_q.pop_front();
                                want_im = exp_im_q.pop_front();
                                chk     = exp_chk_q.pop_front();
                                tag     = exp_tag_q.pop_front();
                                // Stage B emits four sums, then four differences
                                kind    = ((tag % 8) < 4) ? KIND_SUM : KIND_DIFF;
                                if (chk) begin
                                        compare_sample("out_re", want_re, out_re, kind, tag);
                                        compare_sample("out_im", want_im, out_im, kind, tag);
                                        checked_count++;
                                        pending_checks--;
                                end
                        end
                end
        end

        initial begin : watchdog
                #(WATCHDOG_TIME);
                report_failure($sformatf(
                        "timeout: only %0d of %0d expected results arrived on out_valid",
                        checked_count, needed_count));
        end

        //////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////

        initial begin : stimulus
                rst_n          = 1'b0;
                discard        = 1'b0;
                frame_count    = 0;
                pending_checks = 0;
                needed_count   = 0;
                checked_count  = 0;
                seen_count     = 0;
                go_idle();
                init_twiddles();
                repeat (5) @(negedge clk);
                rst_n = 1'b1;
                @(negedge clk);

                // Impulse, one nonzero output per stage-B quarter
                clear_frame();
                frame_re[0] = 300;
                frame_im[0] = -200;
                for (int q = 0; q < 4; q++) begin
                        ref_re[4 * q] = 150;
                        ref_im[4 * q] = -100;
                end
                queue_expected(1'b1);
                drive_frame(1'b0);
                send_flush(1'b0);

                // Constant frame, only the first four outputs are nonzero
                clear_frame();
                for (int k = 0; k < FFT_POINTS; k++) begin
                        frame_re[k] = 200;
                        frame_im[k] = 120;
                end
                for (int k = 0; k < 4; k++) begin
                        ref_re[k] = 400;
                        ref_im[k] = 240;
                end
                queue_expected(1'b1);
                drive_frame(1'b0);
                send_flush(1'b0);

                // Random frames, no gaps
                for (int f = 0; f < N_RANDOM; f++) begin
                        for (int k = 0; k < FFT_POINTS; k++) begin
                                frame_re[k] = random_sample();
                                frame_im[k] = random_sample();
                                saved_re[f * FFT_POINTS + k] = frame_re[k];
                                saved_im[f * FFT_POINTS + k] = frame_im[k];
                        end
                        send_checked_frame(1'b0);
                end

                // Same frames again with holes in in_valid
                for (int f = 0; f < N_RANDOM; f++) begin
                        for (int k = 0; k < FFT_POINTS; k++) begin
                                frame_re[k] = saved_re[f * FFT_POINTS + k];
                                frame_im[k] = saved_im[f * FFT_POINTS + k];
                        end
                        send_checked_frame(1'b1);
                end

                // Corners of the input range, largest growth in every stage
                for (int c = 0; c < N_CORNER; c++) begin
                        load_corner(c);
                        send_checked_frame(1'b0);
                end

                // Reset in the middle of a frame
                wait_checks_done();
                discard = 1'b1;
                exp_re_q.delete();
                exp_im_q.delete();
                exp_chk_q.delete();
                exp_tag_q.delete();
                for (int k = 0; k < N_PARTIAL; k++) begin
                        drive_sample(random_sample(), 0, 1'b0);
                end
                rst_n = 1'b0;
                go_idle();
                repeat (5) @(negedge clk);
                rst_n      = 1'b1;
                discard    = 1'b0;
                seen_count = 0;
                repeat (16) begin
                        @(negedge clk);
                        if (out_valid !== 1'b0) begin
                                report_failure("out_valid went high after reset before new input");
                        end
                end
                for (int k = 0; k < FFT_POINTS; k++) begin
                        frame_re[k] = random_sample();
                        frame_im[k] = random_sample();
                end
                send_checked_frame(1'b0);

                wait_checks_done();
                repeat (4) @(negedge clk);
                if (seen_count == RESULTS_AFTER_RESET) begin
                        $display("** PASS **");
                        $finish;
                end else begin
                        report_failure($sformatf(
                                "wrong number of results after reset: %0d seen, %0d expected",
                                seen_count, RESULTS_AFTER_RESET));
                end
        end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
        parameter int PERIOD = 40
) (
        output logic clk
);

        // Free running, first rising edge after half a period
        initial begin
                clk = 1'b0;
                forever begin
                        #(PERIOD / 2) clk = ~clk;
                end
        end

endmodule
